// File: Bender.yml
package:
  name: pipeline_cpu

sources:
  # Package first, then the RTL leaf modules and the top level.
  - hdl/cpuPkg.sv
  - hdl/alu.sv
  - hdl/regFile.sv
  - hdl/controlUnit.sv
  - hdl/pipelineCpu.sv

  - target: test
    files:
      - testbench/pipelineCpu_properties.sv
      - testbench/pipelineCpuTb.sv

// File: hdl/alu.sv
// 32-bit combinational ALU; slt compares as signed, overflow is ignored and not flagged.
`default_nettype none

module alu import cpuPkg::*; (
  input  wordT   operandA,
  input  wordT   operandB,
  input  aluCmdE cmd,
  output wordT   result,
  output logic   zero
);

  always_comb begin
    case (cmd)
      aluAdd: begin
        result = operandA + operandB;
      end
      aluSub: begin
        result = operandA - operandB;
      end
      aluAnd: begin
        result = operandA & operandB;
      end
      aluOr: begin
        result = operandA | operandB;
      end
      // Signed compare, result is 0 or 1.
      aluSlt: begin
        result = {31'd0, $signed(operandA) < $signed(operandB)};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Used by beq after a subtract.
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/controlUnit.sv
// Purely combinational decode; unknown opcodes and function codes decode to a harmless bundle.
`default_nettype none

module controlUnit import cpuPkg::*; (
  input  instrU instr,
  output ctrlT  ctrl
);

  always_comb begin
    // Default is a bubble. Nothing written, no branch.
    ctrl = '0;
    ctrl.aluCmd = aluAdd;

    case (instr.i.opcode)
      opRType: begin
        ctrl.regDst = 1'b1;
        case (instr.r.funct)
          fnAdd: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluCmd   = aluAdd;
          end
          fnSub: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluCmd   = aluSub;
          end
          fnAnd: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluCmd   = aluAnd;
          end
          fnOr: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluCmd   = aluOr;
          end
          fnSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluCmd   = aluSlt;
          end
          // fnNop and unsupported codes write nothing.
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      // Compare by subtraction, the zero flag decides.
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluCmd = aluSub;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/cpuPkg.sv
// Fixed 32-bit MIPS subset without shifts, jumps or byte access; the all-zero word is a nop.
`default_nettype none

package cpuPkg;

  // Machine word and register index.
  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;

  // Primary opcodes kept from the instruction set.
  typedef enum logic [5:0] {
    opRType = 6'd0,
    opBeq   = 6'd4,
    opAddi  = 6'd8,
    opLw    = 6'd35,
    opSw    = 6'd43
  } opcodeE;

  // R-type function codes. Code 0 is the nop.
  typedef enum logic [5:0] {
    fnNop = 6'd0,
    fnAdd = 6'd32,
    fnSub = 6'd34,
    fnAnd = 6'd36,
    fnOr  = 6'd37,
    fnSlt = 6'd42
  } functE;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluCmdE;

  // R-type layout.
  typedef struct packed {
    opcodeE     opcode;
    regAddrT    rs;
    regAddrT    rt;
    regAddrT    rd;
    logic [4:0] shamt;
    functE      funct;
  } rFieldsT;

  // I-type layout, shared by addi, lw, sw and beq.
  typedef struct packed {
    opcodeE      opcode;
    regAddrT     rs;
    regAddrT     rt;
    logic [15:0] imm;
  } iFieldsT;

  // One instruction word, two views.
  typedef union packed {
    rFieldsT r;
    iFieldsT i;
  } instrU;

  // Control bundle produced in decode.
  typedef struct packed {
    logic   regWrite;
    logic   memToReg;
    logic   memWrite;
    logic   branch;
    aluCmdE aluCmd;
    logic   aluSrc;
    logic   regDst;
  } ctrlT;

  typedef struct packed {
    instrU instr;
    wordT  pcPlus4;
  } ifIdT;

  typedef struct packed {
    ctrlT    ctrl;
    wordT    readData1;
    wordT    readData2;
    regAddrT rt;
    regAddrT rd;
    wordT    signImm;
    wordT    pcPlus4;
  } idExT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    memWrite;
    logic    branch;
    logic    zero;
    wordT    aluOut;
    wordT    writeData;
    regAddrT writeReg;
    wordT    pcBranch;
  } exMemT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    wordT    aluOut;
    wordT    readData;
    regAddrT writeReg;
  } memWbT;

endpackage

`default_nettype wire

// File: hdl/pipelineCpu.sv
// Five stages with no hazard logic, no forwarding and no flush; three delay slots after beq.
`default_nettype none

module pipelineCpu import cpuPkg::*; #(
  parameter wordT resetAddress = 32'h0000_0000
) (
  input  logic clk,
  input  logic arstN,
  output wordT instructionAddress,
  input  wordT instruction,
  output wordT dataMemAddress,
  output wordT dataOut,
  output logic memWriteEnable,
  input  wordT dataIn
);

  // Fetch.
  wordT pc;
  wordT pcPlus4;
  wordT pcNext;
  logic pcSrc;

  // Stage registers and their next values.
  ifIdT  ifIdD;
  ifIdT  ifId;
  idExT  idExD;
  idExT  idEx;
  exMemT exMemD;
  exMemT exMem;
  memWbT memWbD;
  memWbT memWb;

  // Decode.
  ctrlT idCtrl;
  wordT rfData1;
  wordT rfData2;

  // Execute.
  wordT    aluB;
  wordT    aluResult;
  logic    aluZero;
  regAddrT writeRegEx;

  // Writeback.
  wordT wbResult;

  // IF. A branch resolved in MEM redirects the next fetch.
  assign pcPlus4 = pc + 32'd4;
  assign pcSrc   = exMem.branch & exMem.zero;
  assign pcNext  = pcSrc ? exMem.pcBranch : pcPlus4;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= resetAddress;
    end else begin
      pc <= pcNext;
    end
  end

  assign instructionAddress = pc;

  always_comb begin
    ifIdD.instr   = instruction;
    ifIdD.pcPlus4 = pcPlus4;
  end

  // Instruction word clears to a nop, so nothing runs twice out of reset.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ifId.instr <= '0;
    end else begin
      ifId <= ifIdD;
    end
  end

  // ID.
  controlUnit decoder (
    .instr(ifId.instr),
    .ctrl (idCtrl)
  );

  regFile regs (
    .clk      (clk),
    .readReg1 (ifId.instr.r.rs),
    .readReg2 (ifId.instr.r.rt),
    .readData1(rfData1),
    .readData2(rfData2),
    .writeReg (memWb.writeReg),
    .writeData(wbResult),
    .regWrite (memWb.regWrite)
  );

  always_comb begin
    idExD.ctrl      = idCtrl;
    idExD.readData1 = rfData1;
    idExD.readData2 = rfData2;
    idExD.rt        = ifId.instr.r.rt;
    idExD.rd        = ifId.instr.r.rd;
    // Sign extension of the I-type immediate.
    idExD.signImm   = {{16{ifId.instr.i.imm[15]}}, ifId.instr.i.imm};
    idExD.pcPlus4   = ifId.pcPlus4;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx.ctrl <= '0;
    end else begin
      idEx <= idExD;
    end
  end

  // EX.
  assign writeRegEx = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
  assign aluB       = idEx.ctrl.aluSrc ? idEx.signImm : idEx.readData2;

  alu exAlu (
    .operandA(idEx.readData1),
    .operandB(aluB),
    .cmd     (idEx.ctrl.aluCmd),
    .result  (aluResult),
    .zero    (aluZero)
  );

  always_comb begin
    exMemD.regWrite  = idEx.ctrl.regWrite;
    exMemD.memToReg  = idEx.ctrl.memToReg;
    exMemD.memWrite  = idEx.ctrl.memWrite;
    exMemD.branch    = idEx.ctrl.branch;
    exMemD.zero      = aluZero;
    exMemD.aluOut    = aluResult;
    exMemD.writeData = idEx.readData2;
    exMemD.writeReg  = writeRegEx;
    // Word offset relative to the delay slot address.
    exMemD.pcBranch  = idEx.pcPlus4 + {idEx.signImm[29:0], 2'b00};
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem.regWrite <= 1'b0;
      exMem.memToReg <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.branch   <= 1'b0;
    end else begin
      exMem <= exMemD;
    end
  end

  // MEM. Load data comes back in the same cycle.
  assign dataMemAddress = exMem.aluOut;
  assign dataOut        = exMem.writeData;
  assign memWriteEnable = exMem.memWrite;

  always_comb begin
    memWbD.regWrite = exMem.regWrite;
    memWbD.memToReg = exMem.memToReg;
    memWbD.aluOut   = exMem.aluOut;
    memWbD.readData = dataIn;
    memWbD.writeReg = exMem.writeReg;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWb.regWrite <= 1'b0;
      memWb.memToReg <= 1'b0;
    end else begin
      memWb <= memWbD;
    end
  end

  // WB.
  assign wbResult = memWb.memToReg ? memWb.readData : memWb.aluOut;

endmodule

`default_nettype wire

// File: hdl/regFile.sv
// Two async read ports, one write port on the rising edge; register 0 reads zero, no reset.
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic    clk,
  input  regAddrT readReg1,
  input  regAddrT readReg2,
  output wordT    readData1,
  output wordT    readData2,
  input  regAddrT writeReg,
  input  wordT    writeData,
  input  logic    regWrite
);

  wordT regs [32];

  // Register 0 is never stored.
  always_ff @(posedge clk) begin
    if (regWrite && (writeReg != '0)) begin
      regs[writeReg] <= writeData;
    end
  end

  // Same-cycle writes bypass the array.
  always_comb begin
    if (readReg1 == '0) begin
      readData1 = '0;
    end else if (regWrite && (writeReg == readReg1)) begin
      readData1 = writeData;
    end else begin
      readData1 = regs[readReg1];
    end
  end

  always_comb begin
    if (readReg2 == '0) begin
      readData2 = '0;
    end else if (regWrite && (writeReg == readReg2)) begin
      readData2 = writeData;
    end else begin
      readData2 = regs[readReg2];
    end
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/cpuPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/controlUnit.sv
hdl/pipelineCpu.sv
testbench/pipelineCpu_properties.sv
testbench/pipelineCpuTb.sv

// File: testbench/pipelineCpuTb.sv
// Memory models live here; programs keep two slots between dependent instructions.
`default_nettype none

module pipelineCpuTb import cpuPkg::*; ();

  localparam wordT resetAddr = 32'h0000_0080;
  localparam int   progBase  = 32;
  localparam wordT loadAddr  = 32'h0000_03f0;
  localparam int   waitLimit = 60;

  typedef enum logic [3:0] {kAdd, kSub, kAnd, kOr, kSlt, kAddi, kLoad, kZero, kBeq} kindE;

  // One table row. For beq rows expected is the number of stores seen.
  typedef struct packed {
    kindE kind;
    wordT a;
    wordT b;
    wordT storeAddr;
    wordT expected;
  } caseT;

  logic clk;
  logic arstN;
  wordT instructionAddress;
  wordT instruction;
  wordT dataMemAddress;
  wordT dataOut;
  wordT dataIn;
  logic memWriteEnable;

  wordT  imem [256];
  wordT  dmem [256];
  caseT  cases [$];
  string names [$];
  wordT  storeAddrs [$];
  wordT  storeData [$];
  int    storeCycles [$];
  int    errors;
  int    checks;
  logic  timedOut;
  wordT  lcgState;

  always #4 clk = ~clk;

  // Both memories answer combinationally.
  assign instruction = imem[instructionAddress[9:2]];
  assign dataIn      = dmem[dataMemAddress[9:2]];

  always @(posedge clk) begin
    if (memWriteEnable) begin
      dmem[dataMemAddress[9:2]] <= dataOut;
    end
  end

  pipelineCpu #(
    .resetAddress(resetAddr)
  ) uut (
    .clk               (clk),
    .arstN             (arstN),
    .instructionAddress(instructionAddress),
    .instruction       (instruction),
    .dataMemAddress    (dataMemAddress),
    .dataOut           (dataOut),
    .memWriteEnable    (memWriteEnable),
    .dataIn            (dataIn)
  );

  function automatic wordT encR(functE fn, regAddrT rs, regAddrT rt, regAddrT rd);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic wordT encI(opcodeE op, regAddrT rs, regAddrT rt, wordT imm);
    return {op, rs, rt, imm[15:0]};
  endfunction

  function automatic wordT nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Instruction-set result of r1 op r2, or r1 plus immediate for addi.
  function automatic wordT refResult(kindE kind, wordT a, wordT b);
    case (kind)
      kAdd, kAddi: return a + b;
      kSub: return a - b;
      kAnd: return a & b;
      kOr: return a | b;
      kSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return 32'd0;
    endcase
  endfunction

  task automatic check(string name, wordT expected, wordT actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic addCase(string name, kindE kind, wordT a, wordT b, wordT addr, wordT exp);
    cases.push_back('{kind, a, b, addr, exp});
    names.push_back(name);
  endtask

  task automatic loadProgram(caseT tc);
    wordT prog [16];
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    prog = '{default: '0};
    prog[0] = encI(opAddi, 5'd0, 5'd1, tc.a);
    prog[1] = encI(opAddi, 5'd0, 5'd2, tc.b);
    case (tc.kind)
      kAdd: prog[4] = encR(fnAdd, 5'd1, 5'd2, 5'd3);
      kSub: prog[4] = encR(fnSub, 5'd1, 5'd2, 5'd3);
      kAnd: prog[4] = encR(fnAnd, 5'd1, 5'd2, 5'd3);
      kOr: prog[4] = encR(fnOr, 5'd1, 5'd2, 5'd3);
      kSlt: prog[4] = encR(fnSlt, 5'd1, 5'd2, 5'd3);
      kAddi: prog[4] = encI(opAddi, 5'd1, 5'd3, tc.b);
      kLoad: begin
        prog[0] = encI(opLw, 5'd0, 5'd1, loadAddr);
        dmem[loadAddr[9:2]] = tc.a;
        prog[4] = encR(fnAdd, 5'd1, 5'd2, 5'd3);
      end
      kZero: prog[4] = encR(fnAdd, 5'd1, 5'd2, 5'd0);
      default: begin
        // Target is word 12, the delay slots are words 5 to 7.
        prog[4]  = encI(opBeq, 5'd1, 5'd2, 32'd7);
        prog[5]  = encI(opSw, 5'd0, 5'd1, tc.storeAddr);
        prog[8]  = encI(opSw, 5'd0, 5'd2, tc.storeAddr + 32'd4);
        prog[12] = encI(opSw, 5'd0, 5'd1, tc.storeAddr + 32'd8);
      end
    endcase
    if (tc.kind != kBeq) begin
      prog[7] = encI(opSw, 5'd0, (tc.kind == kZero) ? 5'd0 : 5'd3, tc.storeAddr);
    end
    for (int i = 0; i < 16; i++) begin
      imem[progBase + i] = prog[i];
    end
  endtask

  task automatic applyReset();
    arstN = 1'b0;
    repeat (10) begin
      @(negedge clk);
      check("reset fetch address", resetAddr, instructionAddress);
      check("reset write enable", 32'd0, {31'd0, memWriteEnable});
      @(posedge clk);
      #1;
    end
    arstN = 1'b1;
  endtask

  task automatic runCase(int idx);
    caseT  tc;
    string name;
    wordT  lastAddr;
    int    cycle;
    int    fetchIdx;
    int    last;
    logic  taken;
    logic  done;
    tc       = cases[idx];
    name     = $sformatf("%s #%0d", names[idx], idx);
    taken    = (tc.kind == kBeq) && (tc.a == tc.b);
    lastAddr = (tc.kind == kBeq) ? tc.storeAddr + 32'd8 : tc.storeAddr;
    loadProgram(tc);
    storeAddrs.delete();
    storeData.delete();
    storeCycles.delete();
    applyReset();
    done  = 1'b0;
    cycle = 0;
    while (!done) begin
      if (cycle >= waitLimit) begin
        $display("Timeout: no store to %h in test %s after %0d cycles", lastAddr, name, cycle);
        timedOut = 1'b1;
        return;
      end
      @(negedge clk);
      // Fetch steps by four, a taken beq jumps four words ahead in cycle 8.
      fetchIdx = (taken && cycle >= 8) ? cycle + 4 : cycle;
      check({name, " fetch address"}, resetAddr + 4 * fetchIdx, instructionAddress);
      if (memWriteEnable) begin
        storeAddrs.push_back(dataMemAddress);
        storeData.push_back(dataOut);
        storeCycles.push_back(cycle);
        // Straight-line programs hold a single store.
        done = (tc.kind != kBeq) || (dataMemAddress == lastAddr);
      end
      @(posedge clk);
      #1;
      cycle++;
    end
    last = storeAddrs.size() - 1;
    if (tc.kind != kBeq) begin
      check({name, " store address"}, tc.storeAddr, storeAddrs[last]);
      check({name, " store data"}, tc.expected, storeData[last]);
      check({name, " store cycle"}, 32'd10, storeCycles[last]);
      check({name, " memory word"}, tc.expected, dmem[tc.storeAddr[9:2]]);
    end else begin
      check({name, " store count"}, tc.expected, storeAddrs.size());
      if (storeAddrs.size() == tc.expected) begin
        check({name, " delay slot store"}, tc.storeAddr, storeAddrs[0]);
        check({name, " delay slot cycle"}, 32'd8, storeCycles[0]);
        if (!taken) begin
          check({name, " fall-through store"}, tc.storeAddr + 32'd4, storeAddrs[1]);
          check({name, " fall-through data"}, tc.b, storeData[1]);
        end
        check({name, " target data"}, tc.a, storeData[last]);
        check({name, " target cycle"}, taken ? 32'd11 : 32'd15, storeCycles[last]);
      end
    end
  endtask

  initial begin
    wordT w;
    wordT a;
    wordT b;
    kindE kind;
    clk      = 1'b0;
    arstN    = 1'b1;
    errors   = 0;
    checks   = 0;
    timedOut = 1'b0;
    lcgState = 32'hf52b_3960;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = i * 32'h9e37_79b9;
    end
    addCase("add", kAdd, 32'd7, 32'd5, 32'h100, 32'd12);
    addCase("sub negative", kSub, 32'd3, 32'd10, 32'h104, 32'hffff_fff9);
    addCase("and", kAnd, 32'h0f0f, 32'h00ff, 32'h108, 32'h0000_000f);
    addCase("or", kOr, 32'h0f00, 32'h00f0, 32'h10c, 32'h0000_0ff0);
    addCase("slt signed", kSlt, 32'hffff_fffe, 32'd1, 32'h110, 32'd1);
    addCase("slt false", kSlt, 32'd9, 32'hffff_fff0, 32'h114, 32'd0);
    addCase("addi negative", kAddi, 32'd100, 32'hffff_ff9c, 32'h118, 32'd0);
    addCase("lw then add", kLoad, 32'h1234_5678, 32'd8, 32'h11c, 32'h1234_5680);
    addCase("write r0", kZero, 32'd4, 32'd6, 32'h120, 32'd0);
    addCase("beq taken", kBeq, 32'd5, 32'd5, 32'h140, 32'd2);
    addCase("beq not taken", kBeq, 32'd3, 32'd7, 32'h150, 32'd3);
    // Random rows use 16-bit signed operands.
    for (int i = 0; i < 8; i++) begin
      w    = nextRand();
      a    = {{16{w[31]}}, w[31:16]};
      w    = nextRand();
      b    = {{16{w[31]}}, w[31:16]};
      kind = kindE'(i % 6);
      addCase("random", kind, a, b, 32'h200 + 4 * i, refResult(kind, a, b));
    end
    #1;
    for (int i = 0; i < cases.size() && !timedOut; i++) begin
      runCase(i);
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.props.failCount);
    if (errors == 0 && uut.props.failCount == 0 && !timedOut) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/pipelineCpu_properties.sv
// Bound into pipelineCpu; assumes a word-aligned reset address and branch targets.
`default_nettype none

module pipelineCpuProperties import cpuPkg::*; (
  input logic  clk,
  input logic  arstN,
  input wordT  instructionAddress,
  input wordT  dataMemAddress,
  input logic  memWriteEnable,
  input logic  pcSrc,
  input exMemT exMem
);

  int failCount = 0;

  // No store leaves the core while reset is held.
  noWriteInReset: assert property (@(posedge clk) !arstN |-> !memWriteEnable)
    else begin
      failCount++;
      $error("memory write enable high during reset");
    end

  fetchAligned: assert property (@(posedge clk) disable iff (!arstN)
    instructionAddress[1:0] == 2'b00)
    else begin
      failCount++;
      $error("instruction address not word aligned");
    end

  // Next fetch is pc plus four, or the branch target resolved in MEM.
  fetchStep: assert property (@(posedge clk) disable iff (!arstN)
    $past(arstN) |-> (instructionAddress == $past(instructionAddress) + 32'd4)
      || ($past(pcSrc) && (instructionAddress == $past(exMem.pcBranch))))
    else begin
      failCount++;
      $error("instruction address neither stepped by four nor branched");
    end

  storeAligned: assert property (@(posedge clk) disable iff (!arstN)
    memWriteEnable |-> dataMemAddress[1:0] == 2'b00)
    else begin
      failCount++;
      $error("store address not word aligned");
    end

endmodule

bind pipelineCpu pipelineCpuProperties props (
  .clk               (clk),
  .arstN             (arstN),
  .instructionAddress(instructionAddress),
  .dataMemAddress    (dataMemAddress),
  .memWriteEnable    (memWriteEnable),
  .pcSrc             (pcSrc),
  .exMem             (exMem)
);

`default_nettype wire
